// ==== common/dhcp_pkg.sv ====
package dhcp_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////
  localparam int opt_len        = 16;                      // bytes per option slot
  localparam int opt_num_tx     = 4;                       // msg type, req ip, client id, host
  localparam int dhcp_hdr_len   = 240;                     // bootp header incl magic cookie
  localparam int opt_tot_len_tx = opt_num_tx*opt_len + 1;  // all slots plus end byte
  localparam int udp_hdr_len    = 8;

  ////////////////////////////////////////////////////////////
  // option codes and fixed values
  ////////////////////////////////////////////////////////////
  localparam logic [7:0] opt_message_type = 8'd53;
  localparam logic [7:0] opt_requested_ip = 8'd50;
  localparam logic [7:0] opt_client_id    = 8'd61;
  localparam logic [7:0] opt_hostname     = 8'd12;
  localparam logic [7:0] opt_pad          = 8'd0;
  localparam logic [7:0] opt_end          = 8'd255;

  localparam logic [7:0] opt_message_type_len = 8'd1;
  localparam logic [7:0] opt_requested_ip_len = 8'd4;
  localparam logic [7:0] opt_client_id_len    = 8'd7;  // htype + 6 byte hw address

  localparam logic [7:0] msg_discover = 8'd1;
  localparam logic [7:0] msg_request  = 8'd3;

  localparam logic [15:0] dhcp_cli_port  = 16'd68;
  localparam logic [15:0] dhcp_srv_port  = 16'd67;
  localparam logic [31:0] magic_cookie   = 32'h63825363;
  localparam logic [31:0] ipv4_broadcast = 32'hffffffff;

  // config register map
  localparam logic [1:0] cfg_addr_mac_hi = 2'd0;  // data[15:0] -> chaddr[47:32]
  localparam logic [1:0] cfg_addr_mac_lo = 2'd1;  // data[31:0] -> chaddr[31:0]
  localparam logic [1:0] cfg_addr_ctrl   = 2'd2;
  localparam int         cfg_ctrl_hostname_bit = 0;
  localparam int         cfg_ctrl_bcast_bit    = 1;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [7:0]  msg_type;
    logic [31:0] xid;
    logic [31:0] req_ip;
    logic        req_ip_pres;  // add requested ip option
  } dhcp_req_t;

  typedef struct packed {
    logic [47:0] chaddr;
    logic        hostname_en;
    logic        bcast_flag;
  } dhcp_cfg_t;

  typedef struct packed {
    logic [1:0]  addr;
    logic [31:0] data;
  } cfg_wr_t;

  // one option slot, field view
  typedef struct packed {
    logic [7:0]                  code;
    logic [7:0]                  len;
    logic [0:opt_len-3][7:0]     payload;  // payload[0] goes out first
  } dhcp_opt_fld_t;

  // slot as sent byte by byte or as code/len/payload
  typedef union packed {
    logic [0:opt_len-1][7:0] raw;  // raw[0] is the code byte
    dhcp_opt_fld_t           fld;
  } dhcp_opt_u;

  typedef struct packed {
    logic [7:0] dat;
    logic       sof;
    logic       eof;
  } dhcp_strm_t;

  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;  // udp length incl udp header
  } udp_meta_t;

endpackage : dhcp_pkg

// ==== dhcp_tx/dhcp_byte_tx.sv ====
module dhcp_byte_tx import dhcp_pkg::*; (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       asm_valid,
  output logic                       asm_ready,
  input  dhcp_opt_u [0:opt_num_tx-1] asm_opts,
  input  logic [7:0]                 asm_opt_bytes,
  input  dhcp_req_t                  asm_req,
  input  dhcp_cfg_t                  cfg,
  output logic                       strm_valid,
  input  logic                       strm_ready,
  output dhcp_strm_t                 strm,
  output logic                       meta_valid,
  output udp_meta_t                  meta
);

  localparam int cnt_w = $clog2(dhcp_hdr_len + opt_tot_len_tx);
  localparam int hdr_w = $clog2(dhcp_hdr_len);
  localparam int ofs_w = $clog2(opt_len);
  localparam int idx_w = $clog2(opt_num_tx);
  localparam int pos_w = ofs_w + idx_w;

  // bootp field offsets
  localparam int hdr_xid    = 4;
  localparam int hdr_flags  = 10;
  localparam int hdr_chaddr = 28;
  localparam int hdr_cookie = 236;

  logic                         busy;
  logic                         load;      // buffer handover
  logic                         take;      // byte accepted
  logic [cnt_w-1:0]             byte_cnt;
  logic [cnt_w-1:0]             last_cnt;  // index of end byte
  logic [pos_w-1:0]             opt_pos;
  logic [idx_w-1:0]             opt_idx;
  logic [ofs_w-1:0]             opt_ofs;
  dhcp_opt_u [0:opt_num_tx-1]   opts_q;
  logic [31:0]                  xid_q;
  logic [47:0]                  chaddr_q;
  logic                         bcast_q;
  logic [0:dhcp_hdr_len-1][7:0] hdr;

  assign asm_ready = ~busy;
  assign load      = asm_valid && asm_ready;
  assign take      = strm_valid && strm_ready;

  ////////////////////////////////////////////////////////////
  // transmit control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy       <= 1'b0;
      strm_valid <= 1'b0;
      meta_valid <= 1'b0;
      byte_cnt   <= '0;
    end else if (load) begin
      busy       <= 1'b1;
      strm_valid <= 1'b1;  // first byte next cycle
      meta_valid <= 1'b1;
      byte_cnt   <= '0;
    end else if (take) begin
      if (byte_cnt == last_cnt) begin
        busy       <= 1'b0;  // ready for next buffer
        strm_valid <= 1'b0;
        meta_valid <= 1'b0;
      end else begin
        byte_cnt <= byte_cnt + 1'b1;  // stalls with strm_ready low
      end
    end
  end

  // frame contents, captured at handover
  always_ff @(posedge clk) begin
    if (load) begin
      opts_q        <= asm_opts;
      last_cnt      <= cnt_w'(dhcp_hdr_len) + cnt_w'(asm_opt_bytes) - 1'b1;
      xid_q         <= asm_req.xid;
      chaddr_q      <= cfg.chaddr;
      bcast_q       <= cfg.bcast_flag;
      meta.src_ip   <= '0;              // no lease yet
      meta.dst_ip   <= ipv4_broadcast;
      meta.src_port <= dhcp_cli_port;
      meta.dst_port <= dhcp_srv_port;
      meta.length   <= 16'(udp_hdr_len + dhcp_hdr_len) + 16'(asm_opt_bytes);
    end
  end

  ////////////////////////////////////////////////////////////
  // byte select
  ////////////////////////////////////////////////////////////
  always_comb begin
    hdr                    = '0;             // secs, addresses, sname, file
    hdr[0]                 = 8'd1;           // op bootrequest
    hdr[1]                 = 8'd1;           // htype ethernet
    hdr[2]                 = 8'd6;           // hlen
    hdr[hdr_xid +: 4]      = xid_q;
    hdr[hdr_flags]         = {bcast_q, 7'd0};  // broadcast flag is bit 15
    hdr[hdr_chaddr +: 6]   = chaddr_q;       // 10 zero bytes follow
    hdr[hdr_cookie +: 4]   = magic_cookie;
  end

  assign opt_pos = pos_w'(byte_cnt - cnt_w'(dhcp_hdr_len));
  assign opt_idx = opt_pos[ofs_w +: idx_w];  // which slot
  assign opt_ofs = opt_pos[ofs_w-1:0];       // byte within slot

  always_comb begin
    strm.sof = strm_valid && (byte_cnt == '0);
    strm.eof = strm_valid && (byte_cnt == last_cnt);
    if (byte_cnt < cnt_w'(dhcp_hdr_len)) begin
      strm.dat = hdr[byte_cnt[hdr_w-1:0]];
    end else if (byte_cnt < last_cnt) begin
      strm.dat = opts_q[opt_idx].raw[opt_ofs];
    end else begin
      strm.dat = opt_end;  // closes option list
    end
  end

endmodule : dhcp_byte_tx

// ==== dhcp_tx/dhcp_opt_asm.sv ====
module dhcp_opt_asm import dhcp_pkg::*; #(
  parameter int                           hostname_len = 8,
  parameter logic [0:hostname_len-1][7:0] hostname     = "localnya"
) (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       req_valid,
  output logic                       req_ready,
  input  dhcp_req_t                  req,
  input  dhcp_cfg_t                  cfg,
  output logic                       asm_valid,
  input  logic                       asm_ready,
  output dhcp_opt_u [0:opt_num_tx-1] asm_opts,
  output logic [7:0]                 asm_opt_bytes,
  output dhcp_req_t                  asm_req
);

  typedef enum logic [1:0] {st_idle, st_load, st_shift, st_hold} state_t;

  state_t                        state;
  dhcp_req_t                     req_q;    // captured request
  dhcp_opt_u [0:opt_num_tx-1]    slot_d;   // prototype slots, built from req_q/cfg
  dhcp_opt_u [0:opt_num_tx-1]    proto;    // slots being shifted out
  dhcp_opt_u [0:opt_num_tx-1]    opt_buf;  // compacted holding buffer
  logic [opt_num_tx-1:0]         pres;     // bit 0 belongs to proto[0]
  logic [$clog2(opt_num_tx)-1:0] slot_cnt;
  logic [$clog2(opt_num_tx)-1:0] wr_idx;   // next free entry in opt_buf
  logic [7:0]                    opt_bytes;
  logic                          last_slot;

  assign last_slot     = (slot_cnt == opt_num_tx-1);
  assign asm_opts      = opt_buf;
  assign asm_opt_bytes = opt_bytes;
  assign asm_req       = req_q;

  ////////////////////////////////////////////////////////////
  // prototype slots
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < opt_num_tx; i++) begin
      slot_d[i].raw = {opt_len{opt_pad}};  // pad tail of every slot
    end
    slot_d[0].fld.code       = opt_message_type;
    slot_d[0].fld.len        = opt_message_type_len;
    slot_d[0].fld.payload[0] = req_q.msg_type;
    slot_d[1].fld.code         = opt_requested_ip;
    slot_d[1].fld.len          = opt_requested_ip_len;
    slot_d[1].fld.payload[0:3] = req_q.req_ip;
    slot_d[2].fld.code         = opt_client_id;
    slot_d[2].fld.len          = opt_client_id_len;
    slot_d[2].fld.payload[0]   = 8'd1;  // htype ethernet
    slot_d[2].fld.payload[1:6] = cfg.chaddr;
    slot_d[3].fld.code                        = opt_hostname;
    slot_d[3].fld.len                         = 8'(hostname_len);
    slot_d[3].fld.payload[0:hostname_len-1]   = hostname;
  end

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= st_idle;
      req_ready <= 1'b0;        // comes up one cycle after reset
      asm_valid <= 1'b0;
      pres      <= '0;
      slot_cnt  <= '0;
      wr_idx    <= '0;
      opt_bytes <= '0;
    end else begin
      case (state)
        st_idle: begin
          req_ready <= 1'b1;
          if (req_valid && req_ready) begin
            req_ready <= 1'b0;
            state     <= st_load;
          end
        end
        st_load: begin          // slots latched this cycle
          pres      <= {cfg.hostname_en, 1'b1, req_q.req_ip_pres, 1'b1};
          slot_cnt  <= '0;
          wr_idx    <= '0;
          opt_bytes <= '0;
          state     <= st_shift;
        end
        st_shift: begin
          pres     <= pres >> 1;
          slot_cnt <= slot_cnt + 1'b1;
          if (pres[0]) begin
            wr_idx <= wr_idx + 1'b1;
          end
          opt_bytes <= opt_bytes + (pres[0] ? 8'(opt_len) : 8'd0)
                                 + (last_slot ? 8'd1 : 8'd0);  // end byte
          if (last_slot) begin
            asm_valid <= 1'b1;
            state     <= st_hold;
          end
        end
        st_hold: begin
          if (asm_ready) begin  // buffer copied downstream
            asm_valid <= 1'b0;
            req_ready <= 1'b1;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_q <= req;
    end
    if (state == st_load) begin
      proto <= slot_d;
    end
    if (state == st_shift) begin
      proto[0:opt_num_tx-2] <= proto[1:opt_num_tx-1];
      if (pres[0]) begin
        opt_buf[wr_idx] <= proto[0];  // keeps slot order
      end
    end
  end

endmodule : dhcp_opt_asm

// ==== logic/dhcp_cfg_regs.sv ====
module dhcp_cfg_regs import dhcp_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  logic      cfg_wr_valid,
  output logic      cfg_wr_ready,
  input  cfg_wr_t   cfg_wr,
  output dhcp_cfg_t cfg
);

  logic wr_en;

  assign cfg_wr_ready = 1'b1;                       // no wait states
  assign wr_en        = cfg_wr_valid && cfg_wr_ready;

  ////////////////////////////////////////////////////////////
  // register write decode
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cfg.chaddr      <= '0;
      cfg.hostname_en <= 1'b0;                      // no hostname option by default
      cfg.bcast_flag  <= 1'b1;                      // ask server for broadcast reply
    end else if (wr_en) begin
      case (cfg_wr.addr)
        cfg_addr_mac_hi: begin
          cfg.chaddr[47:32] <= cfg_wr.data[15:0];   // upper 16 bits only
        end
        cfg_addr_mac_lo: begin
          cfg.chaddr[31:0] <= cfg_wr.data;
        end
        cfg_addr_ctrl: begin
          cfg.hostname_en <= cfg_wr.data[cfg_ctrl_hostname_bit];
          cfg.bcast_flag  <= cfg_wr.data[cfg_ctrl_bcast_bit];
        end
        default: ;                                  // unmapped address is ignored
      endcase
    end
  end

endmodule : dhcp_cfg_regs

// ==== logic/dhcp_tx_top.sv ====
module dhcp_tx_top import dhcp_pkg::*; #(
  parameter int                           hostname_len = 8,
  parameter logic [0:hostname_len-1][7:0] hostname     = "localnya"
) (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       cfg_wr_valid,
  output logic       cfg_wr_ready,
  input  cfg_wr_t    cfg_wr,
  input  logic       req_valid,
  output logic       req_ready,
  input  dhcp_req_t  req,
  output logic       strm_valid,
  input  logic       strm_ready,
  output dhcp_strm_t strm,
  output logic       meta_valid,
  output udp_meta_t  meta
);

  dhcp_cfg_t                  cfg;
  logic                       asm_valid;
  logic                       asm_ready;
  dhcp_opt_u [0:opt_num_tx-1] asm_opts;
  logic [7:0]                 asm_opt_bytes;  // incl end byte
  dhcp_req_t                  asm_req;

  // hw address and control bits
  dhcp_cfg_regs dhcp_cfg_regs_inst (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .cfg_wr_valid (cfg_wr_valid),
    .cfg_wr_ready (cfg_wr_ready),
    .cfg_wr       (cfg_wr),
    .cfg          (cfg)
  );

  dhcp_opt_asm #(
    .hostname_len (hostname_len),
    .hostname     (hostname)
  ) dhcp_opt_asm_inst (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .cfg           (cfg),
    .asm_valid     (asm_valid),
    .asm_ready     (asm_ready),
    .asm_opts      (asm_opts),
    .asm_opt_bytes (asm_opt_bytes),
    .asm_req       (asm_req)
  );

  dhcp_byte_tx dhcp_byte_tx_inst (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .asm_valid     (asm_valid),
    .asm_ready     (asm_ready),
    .asm_opts      (asm_opts),
    .asm_opt_bytes (asm_opt_bytes),
    .asm_req       (asm_req),
    .cfg           (cfg),
    .strm_valid    (strm_valid),
    .strm_ready    (strm_ready),
    .strm          (strm),
    .meta_valid    (meta_valid),
    .meta          (meta)
  );

endmodule : dhcp_tx_top

// ==== project.f ====
+incdir+tests
common/dhcp_pkg.sv
logic/dhcp_cfg_regs.sv
dhcp_tx/dhcp_opt_asm.sv
dhcp_tx/dhcp_byte_tx.sv
logic/dhcp_tx_top.sv
tests/dhcp_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the dhcp transmit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module dhcp_tx_tb -o sim_dhcp_tx
./obj_dir/sim_dhcp_tx > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation done, no failure reported"

// ==== tests/dhcp_tx_ref.svh ====
`ifndef DHCP_TX_REF_SVH
`define DHCP_TX_REF_SVH

localparam int frame_max = dhcp_hdr_len + opt_tot_len_tx;  // longest frame

// expected dhcp payload for one request, returns its byte count
function automatic int ref_frame(input dhcp_req_t r, input dhcp_cfg_t c,
                                 output logic [7:0] frm [0:frame_max-1]);
  int n;
  for (int i = 0; i < frame_max; i++) begin
    frm[i] = 8'h00;                              // zero fields and slot padding
  end
  frm[0] = 8'd1;                                 // op bootrequest
  frm[1] = 8'd1;                                 // htype ethernet
  frm[2] = 8'd6;                                 // hlen
  for (int i = 0; i < 4; i++) begin
    frm[4+i]   = r.xid[31-8*i -: 8];             // msb first on the wire
    frm[236+i] = magic_cookie[31-8*i -: 8];
  end
  frm[10] = {c.bcast_flag, 7'd0};                // flags bit 15
  for (int i = 0; i < 6; i++) begin
    frm[28+i] = c.chaddr[47-8*i -: 8];
  end
  n = dhcp_hdr_len;
  frm[n]   = opt_message_type;                   // always present
  frm[n+1] = 8'd1;
  frm[n+2] = r.msg_type;
  n += opt_len;
  if (r.req_ip_pres) begin
    frm[n]   = opt_requested_ip;
    frm[n+1] = 8'd4;
    for (int i = 0; i < 4; i++) begin
      frm[n+2+i] = r.req_ip[31-8*i -: 8];
    end
    n += opt_len;
  end
  frm[n]   = opt_client_id;
  frm[n+1] = 8'd7;
  frm[n+2] = 8'd1;                               // htype ahead of hw address
  for (int i = 0; i < 6; i++) begin
    frm[n+3+i] = c.chaddr[47-8*i -: 8];
  end
  n += opt_len;
  if (c.hostname_en) begin
    frm[n]   = opt_hostname;
    frm[n+1] = 8'(hostname_len);
    for (int i = 0; i < hostname_len; i++) begin
      frm[n+2+i] = hostname[i];
    end
    n += opt_len;
  end
  frm[n] = opt_end;
  return n + 1;
endfunction

// 16 bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

`endif

// ==== tests/dhcp_tx_tb.sv ====
module dhcp_tx_tb import dhcp_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int                           hostname_len   = 8;
  localparam logic [0:hostname_len-1][7:0] hostname       = "localnya";
  localparam int                           n_tests        = 6;
  localparam int                           timeout_cycles = n_tests * 4 * 330 + 1000;

  `include "dhcp_tx_ref.svh"

  logic       clk = 1'b0;
  logic       fsm_rst;
  logic       cfg_wr_valid;
  logic       cfg_wr_ready;
  cfg_wr_t    cfg_wr;
  logic       req_valid;
  logic       req_ready;
  dhcp_req_t  req;
  logic       strm_valid;
  logic       strm_ready;
  dhcp_strm_t strm;
  logic       meta_valid;
  udp_meta_t  meta;

  ////////////////////////////////////////////////////////////
  // scoreboard state
  ////////////////////////////////////////////////////////////
  dhcp_req_t  exp_req[$];          // accepted requests in order
  dhcp_cfg_t  exp_cfg[$];          // config in force at accept
  dhcp_cfg_t  model_cfg;           // shadow of the config regs
  logic [9:0] rx_byte[$];          // sof, eof, data
  int         rx_start[$];
  int         rx_len[$];
  udp_meta_t  rx_meta[$];
  logic       rx_meta_bad[$];
  int         frames_rx  = 0;
  int         cmp_cnt    = 0;      // frames compared so far
  int         err_cnt    = 0;
  int         chk_cnt    = 0;
  int         open_errs  = 0;      // sof/eof framing faults
  int         test_num   = 0;
  int         test_errs  = 0;
  int         cyc        = 0;
  logic       in_frame   = 1'b0;
  logic       meta_bad;
  int         cur_len;
  int         cur_start;
  udp_meta_t  cur_meta;
  logic       bp_en      = 1'b0;
  logic [15:0] lfsr_state = 16'd37;

  dhcp_tx_top #(
    .hostname_len (hostname_len),
    .hostname     (hostname)
  ) dhcp_tx_top_inst (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .cfg_wr_valid (cfg_wr_valid),
    .cfg_wr_ready (cfg_wr_ready),
    .cfg_wr       (cfg_wr),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req          (req),
    .strm_valid   (strm_valid),
    .strm_ready   (strm_ready),
    .strm         (strm),
    .meta_valid   (meta_valid),
    .meta         (meta)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0d ns: %s: got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset();
    fsm_rst = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    fsm_rst               = 1'b0;
    model_cfg.chaddr      = '0;     // reset values of the regs
    model_cfg.hostname_en = 1'b0;
    model_cfg.bcast_flag  = 1'b1;
  endtask

  task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
    logic done;
    cfg_wr_valid = 1'b1;
    cfg_wr.addr  = addr;
    cfg_wr.data  = data;
    done         = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = cfg_wr_ready;          // what the next edge sees
      check_val(64'(cfg_wr_ready), 64'(1), "cfg_wr_ready high on every write");
      @(posedge clk);
      #2;
    end
    cfg_wr_valid = 1'b0;
    case (addr)
      cfg_addr_mac_hi: model_cfg.chaddr[47:32] = data[15:0];
      cfg_addr_mac_lo: model_cfg.chaddr[31:0]  = data;
      cfg_addr_ctrl: begin
        model_cfg.hostname_en = data[0];
        model_cfg.bcast_flag  = data[1];
      end
      default: ;                    // unmapped
    endcase
  endtask

  task automatic send_req(input logic [7:0] msg, input logic [31:0] xid,
                          input logic [31:0] ip, input logic ip_pres);
    logic done;
    req_valid       = 1'b1;
    req.msg_type    = msg;
    req.xid         = xid;
    req.req_ip      = ip;
    req.req_ip_pres = ip_pres;
    done            = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = req_ready;
      @(posedge clk);
      #2;
    end
    req_valid = 1'b0;
    exp_req.push_back(req);
    exp_cfg.push_back(model_cfg);
  endtask

  task automatic wait_frames(input int n);
    while (cmp_cnt < n) begin
      @(posedge clk);
    end
    #2;
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("test %0d (%s): %s", test_num, name, (err_cnt == test_errs) ? "ok" : "FAILED");
    test_errs = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // stream ready is random while back-pressure is on
  ////////////////////////////////////////////////////////////
  initial begin : ready_drive
    strm_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      if (bp_en) begin
        lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        strm_ready = lfsr_state[0];
      end else begin
        strm_ready = 1'b1;
      end
    end
  end

  // collector samples mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (fsm_rst) begin
      in_frame = 1'b0;                        // partial frame dropped
    end else if (strm_valid && strm_ready) begin
      if (strm.sof || !in_frame) begin
        if (in_frame) begin
          open_errs++;
          $display("frame %0d: new sof at %0d ns before its eof byte", frames_rx, $time);
        end
        if (!strm.sof) begin
          open_errs++;
          $display("frame %0d: first byte at %0d ns has no sof", frames_rx, $time);
        end
        in_frame  = 1'b1;
        cur_start = rx_byte.size();
        cur_len   = 0;
        cur_meta  = meta;
        meta_bad  = 1'b0;
      end
      if (!meta_valid || meta != cur_meta) begin
        meta_bad = 1'b1;                      // meta must hold all frame long
      end
      rx_byte.push_back({strm.sof, strm.eof, strm.dat});
      cur_len++;
      if (strm.eof) begin
        rx_start.push_back(cur_start);
        rx_len.push_back(cur_len);
        rx_meta.push_back(cur_meta);
        rx_meta_bad.push_back(meta_bad);
        in_frame = 1'b0;
        frames_rx++;
      end
    end
  end

  initial begin : frame_compare
    logic [7:0] exp_frm [0:frame_max-1];
    int         n;
    int         base;
    forever begin
      while (frames_rx <= cmp_cnt) begin
        @(posedge clk);
      end
      n    = ref_frame(exp_req[cmp_cnt], exp_cfg[cmp_cnt], exp_frm);
      base = rx_start[cmp_cnt];
      check_val(64'(rx_len[cmp_cnt]), 64'(n), $sformatf("frame %0d length", cmp_cnt));
      for (int i = 0; i < n && i < rx_len[cmp_cnt]; i++) begin
        check_val(64'(rx_byte[base+i]), 64'({i == 0, i == n-1, exp_frm[i]}),
                  $sformatf("frame %0d byte %0d sof/eof/data", cmp_cnt, i));
      end
      check_val(64'(rx_meta[cmp_cnt].src_ip), 64'(0), "meta src_ip");
      check_val(64'(rx_meta[cmp_cnt].dst_ip), 64'(32'hffffffff), "meta dst_ip");
      check_val(64'(rx_meta[cmp_cnt].src_port), 64'(68), "meta src_port");
      check_val(64'(rx_meta[cmp_cnt].dst_port), 64'(67), "meta dst_port");
      check_val(64'(rx_meta[cmp_cnt].length), 64'(n + 8), "meta udp length");
      check_val(64'(rx_meta_bad[cmp_cnt]), 64'(0), "meta valid and stable over frame");
      cmp_cnt++;
    end
  end

  // hang guard
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= timeout_cycles) begin
      if (in_frame) begin
        $display("timeout after %0d cycles: a frame started but its eof never came", cyc);
      end else begin
        $display("timeout after %0d cycles: expected frames did not arrive", cyc);
      end
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  initial begin : stimulus
    int first;
    int errs;
    fsm_rst      = 1'b1;
    cfg_wr_valid = 1'b0;
    cfg_wr       = '0;
    req_valid    = 1'b0;
    req          = '0;
    apply_reset();

    send_req(msg_discover, 32'h3903f326, 32'h0, 1'b0);   // default config
    wait_frames(1);
    check_val(64'(rx_len[0]), 64'(240 + 32 + 1), "discover frame length");
    check_val(64'(rx_meta[0].length), 64'(240 + 32 + 1 + 8), "discover udp length");
    end_test("discover, default config");

    cfg_write(cfg_addr_ctrl, 32'h3);                       // hostname and bcast on
    send_req(msg_request, 32'h11223344, 32'hc0a80164, 1'b1);
    wait_frames(2);
    end_test("request, all options");

    cfg_write(cfg_addr_mac_hi, 32'h0000_0a1b);
    cfg_write(cfg_addr_mac_lo, 32'h2c3d_4e5f);
    cfg_write(cfg_addr_ctrl, 32'h0);                       // bcast off
    cfg_write(2'd3, 32'hffff_ffff);                        // unmapped address has no effect
    send_req(msg_discover, 32'h55667788, 32'h0, 1'b0);
    wait_frames(3);
    cfg_write(cfg_addr_mac_hi, 32'hdead_0102);             // upper half dropped
    cfg_write(cfg_addr_ctrl, 32'h2);
    send_req(msg_request, 32'h99aabbcc, 32'h0a000001, 1'b0);
    wait_frames(4);
    end_test("config registers");

    cfg_write(cfg_addr_ctrl, 32'h3);
    bp_en = 1'b1;
    send_req(msg_request, 32'hcafe0001, 32'h0a000002, 1'b1);
    send_req(msg_discover, 32'hcafe0002, 32'h0, 1'b0);
    wait_frames(6);
    bp_en = 1'b0;
    end_test("back-pressure");

    first = cmp_cnt;
    send_req(msg_discover, 32'h0000_0a0a, 32'h0, 1'b0);
    send_req(msg_request, 32'h0000_0b0b, 32'h0a000003, 1'b1);
    @(negedge clk);
    check_val(64'({strm_valid, cmp_cnt == first}), 64'(2'b11),
              "second request accepted while first frame streams");
    @(posedge clk);
    #2;
    send_req(msg_request, 32'h0000_0c0c, 32'h0a000004, 1'b0);
    wait_frames(first + 3);
    end_test("back-to-back requests");

    send_req(msg_request, 32'h0badf00d, 32'h0a000005, 1'b1);
    do begin
      @(negedge clk);
    end while (!strm_valid);
    repeat (10) @(posedge clk);                            // a few bytes out
    #2;
    apply_reset();
    void'(exp_req.pop_back());                             // cut off by reset
    void'(exp_cfg.pop_back());
    @(negedge clk);
    check_val(64'({strm_valid, meta_valid, req_ready, strm.sof, strm.eof}), 64'(0),
              "outputs low in first cycle after reset");
    @(negedge clk);
    check_val(64'(req_ready), 64'(1), "req_ready up one cycle after reset");
    @(posedge clk);
    #2;
    send_req(msg_discover, 32'h7e57_0006, 32'h0, 1'b0);    // recovers with defaults
    wait_frames(cmp_cnt + 1);
    end_test("reset");

    errs = err_cnt + open_errs;
    $display("%0d tests, %0d checks, %0d errors", test_num, chk_cnt, errs);
    if (errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : dhcp_tx_tb
